//--- src/render_pkg.sv
package render_pkg;

    // signed fixed point, 21 fraction bits
    typedef logic signed [31:0] fp;

    // x in [95:64], y in [63:32], z in [31:0]
    typedef logic [95:0] vec3;

    typedef logic [10:0] pix_coord_t;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_BUSY,
        LANE_WAITING,
        LANE_DONE
    } lane_state_t;

    function automatic fp vec_x(input vec3 v);
        return v[95:64];
    endfunction

    function automatic fp vec_y(input vec3 v);
        return v[63:32];
    endfunction

    function automatic fp vec_z(input vec3 v);
        return v[31:0];
    endfunction

endpackage

//--- src/ray_unit.sv
`timescale 1ns/1ns

module ray_unit #(
    parameter int SCREEN_WIDTH = 8,
    parameter int SCREEN_HEIGHT = 4,
    parameter int MAX_STEPS = 16
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   ray_start,
    input  render_pkg::pix_coord_t pix_x,
    input  render_pkg::pix_coord_t pix_y,
    input  render_pkg::vec3        camera_forward,
    input  render_pkg::vec3        camera_right,
    input  render_pkg::vec3        camera_up,
    input  render_pkg::vec3        ray_origin,
    output logic                   ray_ready,
    output logic                   ray_done,
    output render_pkg::vec3        point,
    output logic                   hit
);

    localparam int STEP_W = $clog2(MAX_STEPS + 1);
    localparam logic signed [11:0] HALF_W = 12'(SCREEN_WIDTH / 2);
    localparam logic signed [11:0] HALF_H = 12'(SCREEN_HEIGHT / 2);

    logic signed [11:0] off_x;
    logic signed [11:0] off_y;
    render_pkg::fp      dir_x;
    render_pkg::fp      dir_y;
    render_pkg::fp      dir_z;
    render_pkg::vec3    dir_c;
    render_pkg::vec3    dir_q;
    logic               busy;
    logic [STEP_W-1:0]  step;
    logic               reached_floor;
    logic               out_of_steps;
    logic               accept;

    function automatic render_pkg::vec3 vec_add(input render_pkg::vec3 a,
                                                input render_pkg::vec3 b);
        render_pkg::fp sx;
        render_pkg::fp sy;
        render_pkg::fp sz;
        sx = render_pkg::vec_x(a) + render_pkg::vec_x(b);
        sy = render_pkg::vec_y(a) + render_pkg::vec_y(b);
        sz = render_pkg::vec_z(a) + render_pkg::vec_z(b);
        return {sx, sy, sz};
    endfunction

    // ray direction from screen offsets, products truncated to one word
    always_comb begin
        off_x = $signed({1'b0, pix_x}) - HALF_W;
        off_y = HALF_H - $signed({1'b0, pix_y});
        dir_x = render_pkg::vec_x(camera_forward) + off_x * render_pkg::vec_x(camera_right)
              + off_y * render_pkg::vec_x(camera_up);
        dir_y = render_pkg::vec_y(camera_forward) + off_x * render_pkg::vec_y(camera_right)
              + off_y * render_pkg::vec_y(camera_up);
        dir_z = render_pkg::vec_z(camera_forward) + off_x * render_pkg::vec_z(camera_right)
              + off_y * render_pkg::vec_z(camera_up);
    end

    assign dir_c         = {dir_x, dir_y, dir_z};
    assign accept        = ray_start && !busy;
    assign reached_floor = render_pkg::vec_y(point) < 0;
    assign out_of_steps  = step == STEP_W'(MAX_STEPS);
    assign ray_ready     = !busy;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy     <= 1'b0;
            ray_done <= 1'b0;
        end else begin
            ray_done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
            end else if (busy && (reached_floor || out_of_steps)) begin
                busy     <= 1'b0;
                ray_done <= 1'b1;
            end
        end
    end

    // first step is taken on the start edge, so step n shows n cycles later
    always_ff @(posedge clk) begin
        if (accept) begin
            dir_q <= dir_c;
            point <= vec_add(ray_origin, dir_c);
            step  <= STEP_W'(1);
        end else if (busy) begin
            if (reached_floor) begin
                hit <= 1'b1;
            end else if (out_of_steps) begin
                hit <= 1'b0;
            end else begin
                point <= vec_add(point, dir_q);
                step  <= step + 1'b1;
            end
        end
    end

endmodule

//--- src/ray_dispatch_fsm.sv
`timescale 1ns/1ns

module ray_dispatch_fsm #(
    parameter int LANE = 0,
    parameter int SCREEN_WIDTH = 8,
    parameter int SCREEN_HEIGHT = 4,
    parameter int RAY_UNITS = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frame_go,
    input  logic                   ray_ready,
    input  logic                   ray_done,
    input  logic                   full,
    output logic                   ray_start,
    output render_pkg::pix_coord_t pix_x,
    output render_pkg::pix_coord_t pix_y,
    output logic                   push
);

    localparam render_pkg::pix_coord_t FIRST_COL = render_pkg::pix_coord_t'(LANE);
    localparam render_pkg::pix_coord_t STEP_X = render_pkg::pix_coord_t'(RAY_UNITS);
    localparam render_pkg::pix_coord_t LAST_COL =
        render_pkg::pix_coord_t'(SCREEN_WIDTH - RAY_UNITS + LANE);
    localparam render_pkg::pix_coord_t LAST_ROW = render_pkg::pix_coord_t'(SCREEN_HEIGHT - 1);

    render_pkg::lane_state_t state;
    render_pkg::pix_coord_t  cur_x;
    render_pkg::pix_coord_t  cur_y;
    logic                    start_pend;
    logic                    row_end;
    logic                    last_pixel;

    assign pix_x      = cur_x;
    assign pix_y      = cur_y;
    assign row_end    = cur_x == LAST_COL;
    assign last_pixel = row_end && (cur_y == LAST_ROW);

    // start waits for a free ray unit
    assign ray_start = start_pend && ray_ready;

    // push in the done cycle if there is room, otherwise once room appears
    assign push = ((state == render_pkg::LANE_BUSY && ray_done) ||
                   state == render_pkg::LANE_WAITING) && !full;

    always_ff @(posedge clk) begin
        if (!rst) begin
            state      <= render_pkg::LANE_IDLE;
            start_pend <= 1'b0;
            cur_x      <= FIRST_COL;
            cur_y      <= '0;
        end else begin
            case (state)
                render_pkg::LANE_IDLE,
                render_pkg::LANE_DONE: begin
                    if (frame_go) begin
                        cur_x      <= FIRST_COL;
                        cur_y      <= '0;
                        start_pend <= 1'b1;
                        state      <= render_pkg::LANE_BUSY;
                    end
                end
                render_pkg::LANE_BUSY: begin
                    if (ray_start) begin
                        start_pend <= 1'b0;
                    end
                    if (ray_done && full) begin
                        state <= render_pkg::LANE_WAITING;
                    end
                end
                default: begin
                end
            endcase

            // result stored, move to the lane's next pixel
            if (push) begin
                if (last_pixel) begin
                    state <= render_pkg::LANE_DONE;
                end else begin
                    if (row_end) begin
                        cur_x <= FIRST_COL;
                        cur_y <= cur_y + 1'b1;
                    end else begin
                        cur_x <= cur_x + STEP_X;
                    end
                    start_pend <= 1'b1;
                    state      <= render_pkg::LANE_BUSY;
                end
            end
        end
    end

endmodule

//--- src/result_fifo.sv
`timescale 1ns/1ns

module result_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            push,
    input  render_pkg::vec3 point_in,
    input  logic            hit_in,
    input  logic            pop,
    output render_pkg::vec3 point_out,
    output logic            hit_out,
    output logic            full,
    output logic            empty
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(FIFO_DEPTH - 1);

    render_pkg::vec3  mem_point [FIFO_DEPTH];
    logic             mem_hit [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    // head word is visible before the pop
    assign point_out = mem_point[rd_ptr];
    assign hit_out   = mem_hit[rd_ptr];
    assign full      = count == CNT_W'(FIFO_DEPTH);
    assign empty     = count == '0;

    always_ff @(posedge clk) begin
        if (push) begin
            mem_point[wr_ptr] <= point_in;
            mem_hit[wr_ptr]   <= hit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

endmodule

//--- src/raster_counter.sv
`timescale 1ns/1ns

module raster_counter #(
    parameter int SCREEN_WIDTH = 8,
    parameter int SCREEN_HEIGHT = 4,
    parameter int RAY_UNITS = 4
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    input  logic [RAY_UNITS-1:0] pop,
    input  logic                 pix_valid,
    input  logic                 pix_ready,
    output logic                 frame_go,
    output logic [((RAY_UNITS > 1) ? $clog2(RAY_UNITS) : 1)-1:0] lane_sel,
    output logic                 busy,
    output logic                 frame_done
);

    localparam int TOTAL = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int CNT_W = $clog2(TOTAL + 1);
    localparam int SEL_W = (RAY_UNITS > 1) ? $clog2(RAY_UNITS) : 1;
    localparam logic [SEL_W-1:0] LAST_LANE = SEL_W'(RAY_UNITS - 1);

    logic [CNT_W-1:0] pop_cnt;
    logic             any_pop;
    logic             last_xfer;

    assign any_pop  = |pop;
    assign frame_go = start && !busy;

    // every pixel has left a FIFO and the final one is leaving the output register
    assign last_xfer = busy && (pop_cnt == CNT_W'(TOTAL)) && pix_valid && pix_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            pop_cnt    <= '0;
            lane_sel   <= '0;
            busy       <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= last_xfer;
            if (frame_go) begin
                busy     <= 1'b1;
                pop_cnt  <= '0;
                lane_sel <= '0;
            end else begin
                if (last_xfer) begin
                    busy <= 1'b0;
                end
                if (any_pop) begin
                    pop_cnt  <= pop_cnt + 1'b1;
                    lane_sel <= (lane_sel == LAST_LANE) ? '0 : lane_sel + 1'b1;
                end
            end
        end
    end

endmodule

//--- src/raster_output.sv
`timescale 1ns/1ns

module raster_output #(
    parameter int RAY_UNITS = 4
) (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [((RAY_UNITS > 1) ? $clog2(RAY_UNITS) : 1)-1:0] lane_sel,
    input  logic [RAY_UNITS-1:0]                 lane_empty,
    input  render_pkg::vec3 [RAY_UNITS-1:0]      lane_point,
    input  logic [RAY_UNITS-1:0]                 lane_hit,
    input  logic                                 pix_ready,
    output logic [RAY_UNITS-1:0]                 pop,
    output logic                                 pix_valid,
    output render_pkg::vec3                      surface_point,
    output logic                                 hit
);

    logic lane_avail;
    logic out_free;
    logic take;

    assign lane_avail = !lane_empty[lane_sel];

    // register is empty or its word leaves this cycle
    assign out_free = !pix_valid || pix_ready;
    assign take     = lane_avail && out_free;

    // only the selected lane is popped
    always_comb begin
        pop = '0;
        if (take) begin
            pop[lane_sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            pix_valid <= 1'b0;
        end else if (take) begin
            pix_valid <= 1'b1;
        end else if (pix_ready) begin
            pix_valid <= 1'b0;
        end
    end

    // data holds while the consumer stalls
    always_ff @(posedge clk) begin
        if (take) begin
            surface_point <= lane_point[lane_sel];
            hit           <= lane_hit[lane_sel];
        end
    end

endmodule

//--- src/render_core.sv
`timescale 1ns/1ns

module render_core #(
    parameter int SCREEN_WIDTH = 8,
    parameter int SCREEN_HEIGHT = 4,
    parameter int RAY_UNITS = 4,
    parameter int FIFO_DEPTH = 4,
    parameter int MAX_STEPS = 16
) (
    input  logic            clk,
    input  logic            rst,
    input  render_pkg::vec3 camera_forward,
    input  render_pkg::vec3 camera_right,
    input  render_pkg::vec3 camera_up,
    input  render_pkg::vec3 ray_origin,
    input  logic            start,
    input  logic            pix_ready,
    output logic            pix_valid,
    output render_pkg::vec3 surface_point,
    output logic            hit,
    output logic            busy,
    output logic            frame_done
);

    localparam int SEL_W = (RAY_UNITS > 1) ? $clog2(RAY_UNITS) : 1;

    logic                            frame_go;
    logic [SEL_W-1:0]                lane_sel;
    logic [RAY_UNITS-1:0]            lane_pop;
    logic [RAY_UNITS-1:0]            lane_empty;
    logic [RAY_UNITS-1:0]            lane_hit;
    render_pkg::vec3 [RAY_UNITS-1:0] lane_point;

    // lane i covers columns i, i+RAY_UNITS, ... of every row
    for (genvar i = 0; i < RAY_UNITS; i++) begin : g_lane
        logic                   ray_start;
        logic                   ray_ready;
        logic                   ray_done;
        logic                   ray_hit;
        logic                   push;
        logic                   full;
        render_pkg::pix_coord_t pix_x;
        render_pkg::pix_coord_t pix_y;
        render_pkg::vec3        ray_point;

        ray_unit #(
            .SCREEN_WIDTH (SCREEN_WIDTH),
            .SCREEN_HEIGHT(SCREEN_HEIGHT),
            .MAX_STEPS    (MAX_STEPS)
        ) ray_unit_inst (
            .clk           (clk),
            .rst           (rst),
            .ray_start     (ray_start),
            .pix_x         (pix_x),
            .pix_y         (pix_y),
            .camera_forward(camera_forward),
            .camera_right  (camera_right),
            .camera_up     (camera_up),
            .ray_origin    (ray_origin),
            .ray_ready     (ray_ready),
            .ray_done      (ray_done),
            .point         (ray_point),
            .hit           (ray_hit)
        );

        ray_dispatch_fsm #(
            .LANE         (i),
            .SCREEN_WIDTH (SCREEN_WIDTH),
            .SCREEN_HEIGHT(SCREEN_HEIGHT),
            .RAY_UNITS    (RAY_UNITS)
        ) dispatch_inst (
            .clk      (clk),
            .rst      (rst),
            .frame_go (frame_go),
            .ray_ready(ray_ready),
            .ray_done (ray_done),
            .full     (full),
            .ray_start(ray_start),
            .pix_x    (pix_x),
            .pix_y    (pix_y),
            .push     (push)
        );

        result_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) fifo_inst (
            .clk      (clk),
            .rst      (rst),
            .push     (push),
            .point_in (ray_point),
            .hit_in   (ray_hit),
            .pop      (lane_pop[i]),
            .point_out(lane_point[i]),
            .hit_out  (lane_hit[i]),
            .full     (full),
            .empty    (lane_empty[i])
        );
    end

    raster_counter #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT),
        .RAY_UNITS    (RAY_UNITS)
    ) counter_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .pop       (lane_pop),
        .pix_valid (pix_valid),
        .pix_ready (pix_ready),
        .frame_go  (frame_go),
        .lane_sel  (lane_sel),
        .busy      (busy),
        .frame_done(frame_done)
    );

    raster_output #(
        .RAY_UNITS(RAY_UNITS)
    ) output_inst (
        .clk          (clk),
        .rst          (rst),
        .lane_sel     (lane_sel),
        .lane_empty   (lane_empty),
        .lane_point   (lane_point),
        .lane_hit     (lane_hit),
        .pix_ready    (pix_ready),
        .pop          (lane_pop),
        .pix_valid    (pix_valid),
        .surface_point(surface_point),
        .hit          (hit)
    );

endmodule

//--- sim/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- sim/render_core_tb.sv
`timescale 1ns/1ns

module render_core_tb;

    localparam int SCREEN_WIDTH = 8;
    localparam int SCREEN_HEIGHT = 4;
    localparam int RAY_UNITS = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int MAX_STEPS = 16;
    localparam int TOTAL = SCREEN_WIDTH * SCREEN_HEIGHT;
    localparam int ROWS = 6;
    localparam int FRAME_TIMEOUT = 3000;
    localparam int ONE = 1 << 21;
    localparam int READY_ALWAYS = 0;
    localparam int READY_RANDOM = 1;
    localparam int READY_STALL = 2;
    localparam int HITS_FROM_MODEL = -1;

    typedef struct {
        render_pkg::vec3 forward;
        render_pkg::vec3 right;
        render_pkg::vec3 up;
        render_pkg::vec3 origin;
        int              ready_mode;
        int              exp_hits;
    } row_t;

    logic            clk;
    logic            rst;
    render_pkg::vec3 camera_forward;
    render_pkg::vec3 camera_right;
    render_pkg::vec3 camera_up;
    render_pkg::vec3 ray_origin;
    logic            start;
    logic            pix_ready;
    logic            pix_valid;
    render_pkg::vec3 surface_point;
    logic            hit;
    logic            busy;
    logic            frame_done;

    row_t            tbl [ROWS];
    render_pkg::vec3 exp_point [TOTAL];
    logic            exp_hit [TOTAL];
    int              seed;
    int              pass_count;
    int              fail_count;
    bit              timed_out;

    tb_clock_gen clock_inst (.clk(clk));

    render_core #(
        .SCREEN_WIDTH (SCREEN_WIDTH),
        .SCREEN_HEIGHT(SCREEN_HEIGHT),
        .RAY_UNITS    (RAY_UNITS),
        .FIFO_DEPTH   (FIFO_DEPTH),
        .MAX_STEPS    (MAX_STEPS)
    ) render_core_inst (
        .clk(clk), .rst(rst), .camera_forward(camera_forward), .camera_right(camera_right),
        .camera_up(camera_up), .ray_origin(ray_origin), .start(start), .pix_ready(pix_ready),
        .pix_valid(pix_valid), .surface_point(surface_point), .hit(hit), .busy(busy),
        .frame_done(frame_done)
    );

    function automatic render_pkg::vec3 make_vec(input int x, input int y, input int z);
        return {x, y, z};
    endfunction

    // k = 0 is x, 1 is y, 2 is z
    function automatic logic signed [31:0] component(input render_pkg::vec3 v, input int k);
        return v[95 - 32 * k -: 32];
    endfunction

    task automatic check(input string name, input logic [95:0] actual,
                         input logic [95:0] expected);
        if (actual !== expected) begin
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic fill_table();
        // mixed hits and misses, step counts differ per column
        tbl[0] = '{make_vec(0, -ONE / 4, ONE), make_vec(ONE, ONE / 32, 0),
                   make_vec(0, ONE / 16, ONE / 8), make_vec(0, 2 * ONE, 0),
                   READY_ALWAYS, HITS_FROM_MODEL};
        // steep down, every ray lands on step 2
        tbl[1] = '{make_vec(0, -ONE, ONE / 2), make_vec(ONE / 4, 0, 0),
                   make_vec(0, 0, ONE / 4), make_vec(ONE, ONE + ONE / 2, 0),
                   READY_ALWAYS, TOTAL};
        // looking up, nothing reaches the floor
        tbl[2] = '{make_vec(0, ONE / 4, ONE), make_vec(ONE / 8, 0, 0),
                   make_vec(0, ONE / 16, 0), make_vec(0, ONE, 0), READY_RANDOM, 0};
        tbl[3] = '{make_vec(ONE / 2, -ONE / 8, ONE), make_vec(ONE / 2, -ONE / 64, 0),
                   make_vec(0, ONE / 32, ONE / 2), make_vec(-ONE, ONE + ONE / 2, ONE),
                   READY_RANDOM, HITS_FROM_MODEL};
        // short marches fill every lane FIFO long before the stall ends
        tbl[4] = tbl[1];
        tbl[4].ready_mode = READY_STALL;
        tbl[5] = '{make_vec(0, -ONE / 2, ONE), make_vec(ONE, ONE / 16, 0),
                   make_vec(0, ONE / 8, 0), make_vec(0, 4 * ONE, ONE),
                   READY_STALL, HITS_FROM_MODEL};
    endtask

    // march every pixel in raster order, floor hit once y goes negative
    task automatic march_model(input row_t r);
        int                 idx;
        int                 k;
        int                 n;
        int                 off_x;
        int                 off_y;
        logic signed [31:0] d [3];
        logic signed [31:0] p [3];
        for (idx = 0; idx < TOTAL; idx++) begin
            off_x = idx % SCREEN_WIDTH - SCREEN_WIDTH / 2;
            off_y = SCREEN_HEIGHT / 2 - idx / SCREEN_WIDTH;
            for (k = 0; k < 3; k++) begin
                d[k] = component(r.forward, k) + off_x * component(r.right, k)
                     + off_y * component(r.up, k);
                p[k] = component(r.origin, k);
            end
            exp_hit[idx] = 1'b0;
            n = 0;
            while (n < MAX_STEPS && !exp_hit[idx]) begin
                for (k = 0; k < 3; k++) begin
                    p[k] = p[k] + d[k];
                end
                n++;
                exp_hit[idx] = p[1] < 0;
            end
            exp_point[idx] = {p[0], p[1], p[2]};
        end
    endtask

    task automatic run_frame(input int r);
        int              cycles;
        int              got;
        int              hits;
        int              want_hits;
        int              errors_before;
        logic            stalled;
        logic            done_seen;
        logic            held_hit;
        render_pkg::vec3 held_point;
        errors_before = fail_count;
        march_model(tbl[r]);
        want_hits = 0;
        for (int i = 0; i < TOTAL; i++) begin
            want_hits += exp_hit[i];
        end
        if (tbl[r].exp_hits != HITS_FROM_MODEL) begin
            want_hits = tbl[r].exp_hits;
        end
        camera_forward = tbl[r].forward;
        camera_right = tbl[r].right;
        camera_up = tbl[r].up;
        ray_origin = tbl[r].origin;
        start = 1'b1;
        @(posedge clk);
        #5;
        check("busy", busy, 1'b1);
        cycles = 0;
        got = 0;
        hits = 0;
        stalled = 1'b0;
        done_seen = 1'b0;
        while (!done_seen && cycles < FRAME_TIMEOUT) begin
            if (stalled) begin
                check("pix_valid", pix_valid, 1'b1);
                check("surface_point", surface_point, held_point);
                check("hit", hit, held_hit);
            end
            if (frame_done) begin
                done_seen = 1'b1;
                check("transfer count", got, TOTAL);
                check("busy", busy, 1'b0);
                check("hit count", hits, want_hits);
            end else begin
                case (tbl[r].ready_mode)
                    READY_RANDOM: pix_ready = 1'($random(seed) & 1);
                    READY_STALL:  pix_ready = cycles >= 40;
                    default:      pix_ready = 1'b1;
                endcase
                // second start while busy must be ignored
                start = cycles == 3;
                if (pix_valid && pix_ready) begin
                    if (got < TOTAL) begin
                        check("surface_point", surface_point, exp_point[got]);
                        check("hit", hit, exp_hit[got]);
                    end else begin
                        $display("row %0d produced more pixels than the screen holds", r);
                        fail_count++;
                    end
                    hits += hit;
                    got++;
                end
                stalled = pix_valid && !pix_ready;
                held_point = surface_point;
                held_hit = hit;
                @(posedge clk);
                #5;
                cycles++;
            end
        end
        if (!done_seen) begin
            $display("row %0d timed out after %0d cycles without frame_done", r, cycles);
            fail_count++;
            timed_out = 1'b1;
        end else begin
            pix_ready = 1'b1;
            // a quiet gap, no stray pixels and a single done pulse
            repeat (6) begin
                @(posedge clk);
                #5;
                check("pix_valid", pix_valid, 1'b0);
                check("frame_done", frame_done, 1'b0);
            end
        end
        $display("row %0d: %0d pixels, %0d hits, %0d errors", r, got, hits,
                 fail_count - errors_before);
    endtask

    initial begin
        seed = 16;
        pass_count = 0;
        fail_count = 0;
        timed_out = 1'b0;
        rst = 1'b0;
        start = 1'b0;
        pix_ready = 1'b1;
        camera_forward = '0;
        camera_right = '0;
        camera_up = '0;
        ray_origin = '0;
        fill_table();
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b1;
        @(posedge clk);
        #5;
        check("pix_valid", pix_valid, 1'b0);
        check("busy", busy, 1'b0);
        check("frame_done", frame_done, 1'b0);
        for (int r = 0; r < ROWS && !timed_out; r++) begin
            run_frame(r);
        end
        $display("checks passed: %0d, failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- vlog.f
src/render_pkg.sv
src/ray_unit.sv
src/ray_dispatch_fsm.sv
src/result_fifo.sv
src/raster_counter.sv
src/raster_output.sv
src/render_core.sv
sim/tb_clock_gen.sv
sim/render_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= render_core_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# the run passes only if the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
